// ==== common/rv64_core_params.svh ====
`ifndef RV64_CORE_PARAMS_SVH
`define RV64_CORE_PARAMS_SVH

// data and register width
`define XLEN 64

// first fetch address after reset
`define PC_START 64'h8000_0000

// instruction memory depth in 32-bit words
`define IMEM_WORDS 256

// data memory depth in doublewords
`define DMEM_DWORDS 256

// custom opcode that stops the core
`define TRAP_OPCODE 7'h6b

`endif

// ==== common/rv64_decode_pkg.sv ====
`default_nettype none

package rv64_decode_pkg;

    // major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_TRAP   = 7'h6b
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_e;

    // branch compare rules
    typedef enum logic [2:0] {
        CMP_EQ, CMP_NE, CMP_LT, CMP_GE, CMP_LTU, CMP_GEU
    } comp_type_e;

    // writeback source, LINK is pc+4
    typedef enum logic [1:0] {
        WB_ALU, WB_MEM, WB_IMM, WB_LINK
    } wb_src_e;

    typedef struct packed {
        logic       rd_en;
        logic       mem_read;
        logic       mem_write;
        logic       inst_branch;
        // set for jal and jalr
        logic       inst_jump;
        logic       inst_jalr;
        logic       inst_trap;
        logic       alu_src_pc;
        logic       alu_src_imm;
        alu_op_e    alu_op;
        comp_type_e comp_type;
        wb_src_e    wb_src;
    } ctrl_t;

endpackage

`default_nettype wire

// ==== common/rv64_commit_pkg.sv ====
`default_nettype none

`include "rv64_core_params.svh"

package rv64_commit_pkg;

    // one retired instruction
    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  pc;
        logic [31:0]       inst;
        logic              wen;
        logic [4:0]        wdest;
        logic [`XLEN-1:0]  wdata;
    } commit_t;

    typedef struct packed {
        logic              valid;
        logic [7:0]        code;
        logic [`XLEN-1:0]  pc;
        logic [63:0]       cycle_cnt;
        logic [63:0]       instr_cnt;
    } trap_t;

endpackage

`default_nettype wire

// ==== hdl/inst_fetch.sv ====
`default_nettype none

`include "rv64_core_params.svh"

module inst_fetch (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   halt,
    input  rv64_decode_pkg::ctrl_t ctrl,
    input  logic                   branch_taken,
    input  logic [`XLEN-1:0]       alu_res,
    input  logic [`XLEN-1:0]       imm,
    output logic [`XLEN-1:0]       pc
);
    import rv64_decode_pkg::*;

    logic [`XLEN-1:0] next_pc;

    always_comb begin
        if (ctrl.inst_jalr) begin
            next_pc = {alu_res[`XLEN-1:1], 1'b0};
        end else if (branch_taken || ctrl.inst_jump) begin
            // taken branch or jal
            next_pc = pc + imm;
        end else begin
            next_pc = pc + `XLEN'd4;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= `PC_START;
        end else if (!halt) begin
            pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

// ==== decode/inst_decode.sv ====
`default_nettype none

`include "rv64_core_params.svh"

module inst_decode (
    input  logic [31:0]            inst,
    output logic [4:0]             rs1_index,
    output logic [4:0]             rs2_index,
    output logic [4:0]             rd_index,
    output logic [`XLEN-1:0]       imm,
    output rv64_decode_pkg::ctrl_t ctrl
);
    import rv64_decode_pkg::*;

    opcode_e          opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] i_imm;
    logic [`XLEN-1:0] s_imm;
    logic [`XLEN-1:0] b_imm;
    logic [`XLEN-1:0] u_imm;
    logic [`XLEN-1:0] j_imm;

    // funct3 to ALU operation, alt selects sub and sra
    function automatic alu_op_e funct_to_alu(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign i_imm = {{52{inst[31]}}, inst[31:20]};
    assign s_imm = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    assign b_imm = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign u_imm = {{32{inst[31]}}, inst[31:12], 12'b0};
    assign j_imm = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    assign rs2_index = inst[24:20];
    assign rd_index  = inst[11:7];

    // trap reads its code from x10
    assign rs1_index = (opcode == OPC_TRAP) ? 5'd10 : inst[19:15];

    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (opcode)
            OPC_OP: begin
                ctrl.rd_en  = 1'b1;
                ctrl.alu_op = funct_to_alu(funct3, funct7[5]);
            end
            OPC_OP_IMM: begin
                ctrl.rd_en       = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                // no subtract form for immediates
                ctrl.alu_op      = funct_to_alu(funct3, (funct3 == 3'b101) && funct7[5]);
                imm              = i_imm;
            end
            OPC_LUI: begin
                ctrl.rd_en  = 1'b1;
                ctrl.wb_src = WB_IMM;
                imm         = u_imm;
            end
            OPC_JAL: begin
                ctrl.rd_en       = 1'b1;
                ctrl.inst_jump   = 1'b1;
                ctrl.alu_src_pc  = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.wb_src      = WB_LINK;
                imm              = j_imm;
            end
            OPC_JALR: begin
                ctrl.rd_en       = 1'b1;
                ctrl.inst_jump   = 1'b1;
                ctrl.inst_jalr   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.wb_src      = WB_LINK;
                imm              = i_imm;
            end
            OPC_BRANCH: begin
                ctrl.inst_branch = (funct3 != 3'b010) && (funct3 != 3'b011);
                ctrl.alu_src_pc  = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                imm              = b_imm;
                case (funct3)
                    3'b001:  ctrl.comp_type = CMP_NE;
                    3'b100:  ctrl.comp_type = CMP_LT;
                    3'b101:  ctrl.comp_type = CMP_GE;
                    3'b110:  ctrl.comp_type = CMP_LTU;
                    3'b111:  ctrl.comp_type = CMP_GEU;
                    default: ctrl.comp_type = CMP_EQ;
                endcase
            end
            OPC_LOAD: begin
                // ld only
                ctrl.rd_en       = (funct3 == 3'b011);
                ctrl.mem_read    = (funct3 == 3'b011);
                ctrl.alu_src_imm = 1'b1;
                ctrl.wb_src      = WB_MEM;
                imm              = i_imm;
            end
            OPC_STORE: begin
                ctrl.mem_write   = (funct3 == 3'b011);
                ctrl.alu_src_imm = 1'b1;
                imm              = s_imm;
            end
            OPC_TRAP: begin
                ctrl.inst_trap = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== execute/alu_exec.sv ====
`default_nettype none

`include "rv64_core_params.svh"

module alu_exec (
    input  rv64_decode_pkg::ctrl_t ctrl,
    input  logic [`XLEN-1:0]       pc,
    input  logic [`XLEN-1:0]       rs1_data,
    input  logic [`XLEN-1:0]       rs2_data,
    input  logic [`XLEN-1:0]       imm,
    output logic [`XLEN-1:0]       alu_res,
    output logic                   branch_taken
);
    import rv64_decode_pkg::*;

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [5:0]       shamt;
    logic             cmp_res;

    assign op_a  = ctrl.alu_src_pc ? pc : rs1_data;
    assign op_b  = ctrl.alu_src_imm ? imm : rs2_data;
    assign shamt = op_b[5:0];

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:  alu_res = op_a + op_b;
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_AND:  alu_res = op_a & op_b;
            ALU_OR:   alu_res = op_a | op_b;
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SLT:  alu_res = {63'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_res = {63'b0, op_a < op_b};
            ALU_SLL:  alu_res = op_a << shamt;
            ALU_SRL:  alu_res = op_a >> shamt;
            ALU_SRA:  alu_res = $signed(op_a) >>> shamt;
            default:  alu_res = op_a + op_b;
        endcase
    end

    // branch condition always looks at the two registers
    always_comb begin
        case (ctrl.comp_type)
            CMP_EQ:  cmp_res = (rs1_data == rs2_data);
            CMP_NE:  cmp_res = (rs1_data != rs2_data);
            CMP_LT:  cmp_res = ($signed(rs1_data) < $signed(rs2_data));
            CMP_GE:  cmp_res = ($signed(rs1_data) >= $signed(rs2_data));
            CMP_LTU: cmp_res = (rs1_data < rs2_data);
            CMP_GEU: cmp_res = (rs1_data >= rs2_data);
            default: cmp_res = 1'b0;
        endcase
    end

    assign branch_taken = ctrl.inst_branch & cmp_res;

endmodule

`default_nettype wire

// ==== hdl/regfile.sv ====
`default_nettype none

`include "rv64_core_params.svh"

module regfile (
    input  logic             clock,
    input  logic             reset,
    input  logic             we,
    input  logic [4:0]       rs1_index,
    input  logic [4:0]       rs2_index,
    input  logic [4:0]       rd_index,
    input  logic [`XLEN-1:0] rd_data,
    output logic [`XLEN-1:0] rs1_data,
    output logic [`XLEN-1:0] rs2_data
);

    logic [`XLEN-1:0] regs [32];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd_index != 5'd0)) begin
            regs[rd_index] <= rd_data;
        end
    end

    // x0 reads zero
    assign rs1_data = (rs1_index == 5'd0) ? '0 : regs[rs1_index];
    assign rs2_data = (rs2_index == 5'd0) ? '0 : regs[rs2_index];

endmodule

`default_nettype wire

// ==== hdl/core_mem.sv ====
`default_nettype none

`include "rv64_core_params.svh"

module core_mem (
    input  logic                   clock,
    input  logic                   imem_load_en,
    input  logic [7:0]             imem_load_addr,
    input  logic [31:0]            imem_load_data,
    input  logic [`XLEN-1:0]       pc,
    output logic [31:0]            inst,
    input  rv64_decode_pkg::ctrl_t ctrl,
    input  logic [`XLEN-1:0]       addr,
    input  logic [`XLEN-1:0]       wdata,
    output logic [`XLEN-1:0]       rdata
);
    import rv64_decode_pkg::*;

    localparam int IMEM_AW = $clog2(`IMEM_WORDS);
    localparam int DMEM_AW = $clog2(`DMEM_DWORDS);

    logic [31:0]       imem [`IMEM_WORDS];
    logic [`XLEN-1:0]  dmem [`DMEM_DWORDS];
    logic [`XLEN-1:0]  pc_off;
    logic [IMEM_AW-1:0] imem_idx;
    logic [DMEM_AW-1:0] dmem_idx;

    // word offset from the reset PC
    assign pc_off   = pc - `PC_START;
    assign imem_idx = pc_off[IMEM_AW+1:2];
    assign dmem_idx = addr[DMEM_AW+2:3];

    // program load port
    always_ff @(posedge clock) begin
        if (imem_load_en) begin
            imem[imem_load_addr] <= imem_load_data;
        end
    end

    assign inst = imem[imem_idx];

    always_ff @(posedge clock) begin
        if (ctrl.mem_write) begin
            dmem[dmem_idx] <= wdata;
        end
    end

    assign rdata = ctrl.mem_read ? dmem[dmem_idx] : '0;

endmodule

`default_nettype wire

// ==== hdl/sim_top.sv ====
`default_nettype none

`include "rv64_core_params.svh"

module sim_top (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     imem_load_en,
    input  logic [7:0]               imem_load_addr,
    input  logic [31:0]              imem_load_data,
    output rv64_commit_pkg::commit_t commit,
    output rv64_commit_pkg::trap_t   trap
);
    import rv64_decode_pkg::*;
    import rv64_commit_pkg::*;

    logic [`XLEN-1:0] pc;
    logic [31:0]      inst;
    logic [4:0]       rs1_index;
    logic [4:0]       rs2_index;
    logic [4:0]       rd_index;
    logic [`XLEN-1:0] imm;
    ctrl_t            ctrl;
    ctrl_t            mem_ctrl;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] alu_res;
    logic             branch_taken;
    logic [`XLEN-1:0] rdata;
    logic [`XLEN-1:0] rd_data;
    logic             halted;
    logic             rf_we;
    logic             wen;

    assign halted = trap.valid;

    // no state changes once the trap has retired
    assign rf_we = ctrl.rd_en & ~halted;
    always_comb begin
        mem_ctrl           = ctrl;
        mem_ctrl.mem_write = ctrl.mem_write & ~halted;
    end

    always_comb begin
        case (ctrl.wb_src)
            WB_MEM:  rd_data = rdata;
            WB_IMM:  rd_data = imm;
            WB_LINK: rd_data = pc + `XLEN'd4;
            default: rd_data = alu_res;
        endcase
    end

    assign wen = ctrl.rd_en && (rd_index != 5'd0);

    inst_fetch i_inst_fetch (
        .clock        (clock),
        .reset        (reset),
        .halt         (halted | ctrl.inst_trap),
        .ctrl         (ctrl),
        .branch_taken (branch_taken),
        .alu_res      (alu_res),
        .imm          (imm),
        .pc           (pc)
    );

    inst_decode i_inst_decode (
        .inst      (inst),
        .rs1_index (rs1_index),
        .rs2_index (rs2_index),
        .rd_index  (rd_index),
        .imm       (imm),
        .ctrl      (ctrl)
    );

    alu_exec i_alu_exec (
        .ctrl         (ctrl),
        .pc           (pc),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .imm          (imm),
        .alu_res      (alu_res),
        .branch_taken (branch_taken)
    );

    regfile i_regfile (
        .clock     (clock),
        .reset     (reset),
        .we        (rf_we),
        .rs1_index (rs1_index),
        .rs2_index (rs2_index),
        .rd_index  (rd_index),
        .rd_data   (rd_data),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data)
    );

    core_mem i_core_mem (
        .clock          (clock),
        .imem_load_en   (imem_load_en),
        .imem_load_addr (imem_load_addr),
        .imem_load_data (imem_load_data),
        .pc             (pc),
        .inst           (inst),
        .ctrl           (mem_ctrl),
        .addr           (alu_res),
        .wdata          (rs2_data),
        .rdata          (rdata)
    );

    // commit record trails the instruction by one cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            commit <= '0;
            trap   <= '0;
        end else if (!halted) begin
            commit.valid    <= 1'b1;
            commit.pc       <= pc;
            commit.inst     <= inst;
            commit.wen      <= wen;
            commit.wdest    <= rd_index;
            commit.wdata    <= wen ? rd_data : '0;
            trap.cycle_cnt  <= trap.cycle_cnt + 64'd1;
            trap.instr_cnt  <= trap.instr_cnt + 64'd1;
            if (ctrl.inst_trap) begin
                trap.valid <= 1'b1;
                // rs1 is steered to x10 for the trap
                trap.code  <= rs1_data[7:0];
                trap.pc    <= pc;
            end
        end else begin
            commit.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== verif/sim_top_assertions.sv ====
`default_nettype none

module sim_top_assertions (
    input logic                     clock,
    input logic                     reset,
    input rv64_commit_pkg::commit_t commit,
    input rv64_commit_pkg::trap_t   trap
);
    timeunit 1ns;
    timeprecision 1ps;

    // registered outputs are cleared by the reset edge
    reset_quiet: assert property (
        @(posedge clock) reset |=> (!commit.valid && !trap.valid)
    ) else $error("commit or trap valid while reset is high");

    // the trap's own commit is the last one
    no_commit_after_trap: assert property (
        @(posedge clock) disable iff (reset) trap.valid |=> !commit.valid
    ) else $error("commit valid after trap");

    wen_needs_dest: assert property (
        @(posedge clock) disable iff (reset)
        (commit.valid && commit.wen) |-> (commit.wdest != 5'd0)
    ) else $error("commit wen set with wdest x0");

endmodule

`default_nettype wire

// ==== verif/sim_top_checker.sv ====
`default_nettype none

`include "rv64_core_params.svh"

module sim_top_checker (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     imem_load_en,
    input  logic [7:0]               imem_load_addr,
    input  logic [31:0]              imem_load_data,
    input  rv64_commit_pkg::commit_t commit,
    input  rv64_commit_pkg::trap_t   trap,
    output int                       error_count,
    output int                       commit_count,
    output logic                     trap_seen
);
    timeunit 1ns;
    timeprecision 1ps;

    import rv64_commit_pkg::*;
    import rv64_decode_pkg::*;

    logic [31:0]      image [`IMEM_WORDS];
    logic [`XLEN-1:0] ref_regs [32];
    logic [`XLEN-1:0] ref_dmem [`DMEM_DWORDS];
    logic [`XLEN-1:0] ref_pc;
    logic [`XLEN-1:0] ref_trap_pc;
    logic [7:0]       ref_code;
    logic             started;
    int               cycle_count;

    // own copy of the program as it goes through the load port
    always @(posedge clock) begin
        if (imem_load_en) begin
            image[imem_load_addr] = imem_load_data;
        end
    end

    function automatic logic [63:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [63:0] a, input logic [63:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[5:0];
            3'b010:  return {63'b0, $signed(a) < $signed(b)};
            3'b011:  return {63'b0, a < b};
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: begin
                if (alt) begin
                    return $signed(a) >>> b[5:0];
                end
                return a >> b[5:0];
            end
        endcase
    endfunction

    // executes one instruction on the reference state
    function automatic commit_t ref_step();
        commit_t     want;
        logic [31:0] in;
        logic [63:0] a, b, i_imm, res, addr, next_pc;
        logic [2:0]  f3;
        logic        taken;
        in      = image[8'((ref_pc - `PC_START) >> 2)];
        a       = ref_regs[in[19:15]];
        b       = ref_regs[in[24:20]];
        f3      = in[14:12];
        i_imm   = {{52{in[31]}}, in[31:20]};
        res     = '0;
        taken   = 1'b0;
        next_pc = ref_pc + 64'd4;
        want    = '0;
        want.valid = 1'b1;
        want.pc    = ref_pc;
        want.inst  = in;
        want.wdest = in[11:7];
        case (in[6:0])
            OPC_OP: begin
                res       = alu_ref(f3, in[30], a, b);
                want.wen  = 1'b1;
            end
            OPC_OP_IMM: begin
                res       = alu_ref(f3, in[30] && (f3 == 3'b101), a, i_imm);
                want.wen  = 1'b1;
            end
            OPC_LUI: begin
                res       = {{32{in[31]}}, in[31:12], 12'b0};
                want.wen  = 1'b1;
            end
            OPC_JAL: begin
                res       = ref_pc + 64'd4;
                next_pc   = ref_pc + {{43{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};
                want.wen  = 1'b1;
            end
            OPC_JALR: begin
                res       = ref_pc + 64'd4;
                next_pc   = (a + i_imm) & ~64'd1;
                want.wen  = 1'b1;
            end
            OPC_BRANCH: begin
                case (f3)
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    3'b101:  taken = ($signed(a) >= $signed(b));
                    3'b110:  taken = (a < b);
                    default: taken = (a >= b);
                endcase
                if (taken) begin
                    next_pc = ref_pc + {{51{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
                end
            end
            OPC_LOAD: begin
                addr      = a + i_imm;
                res       = ref_dmem[addr[10:3]];
                want.wen  = 1'b1;
            end
            OPC_STORE: begin
                addr = a + {{52{in[31]}}, in[31:25], in[11:7]};
                ref_dmem[addr[10:3]] = b;
            end
            `TRAP_OPCODE: begin
                next_pc     = ref_pc;
                ref_code    = ref_regs[10][7:0];
                ref_trap_pc = ref_pc;
            end
            default: begin
            end
        endcase
        if (want.wen && (in[11:7] != 5'd0)) begin
            ref_regs[in[11:7]] = res;
            want.wdata = res;
        end else begin
            want.wen = 1'b0;
        end
        ref_pc = next_pc;
        return want;
    endfunction

    task automatic mismatch(input string what, input logic [63:0] got, input logic [63:0] exp_val);
        $display("error %0t: %s is %h, expected %h", $time, what, got, exp_val);
        error_count++;
    endtask

    // outputs settle after the rising edge, so compare on the falling one
    always @(negedge clock) begin : compare
        commit_t want;
        if (reset) begin
            ref_pc       = `PC_START;
            error_count  = 0;
            commit_count = 0;
            cycle_count  = 0;
            trap_seen    = 1'b0;
            started      = 1'b0;
            for (int i = 0; i < 32; i++) begin
                ref_regs[i] = '0;
            end
            for (int i = 0; i < `DMEM_DWORDS; i++) begin
                ref_dmem[i] = '0;
            end
        end else begin
            if (commit.valid && trap_seen) begin
                $display("a commit retired after the trap at time %0t", $time);
                error_count++;
            end else if (commit.valid) begin
                want = ref_step();
                if (commit.pc !== want.pc) mismatch("commit pc", commit.pc, want.pc);
                if (commit.inst !== want.inst) mismatch("commit inst", commit.inst, want.inst);
                if (commit.wen !== want.wen) mismatch("commit wen", commit.wen, want.wen);
                if (commit.wdest !== want.wdest) mismatch("commit wdest", commit.wdest, want.wdest);
                if (commit.wdata !== want.wdata) mismatch("commit wdata", commit.wdata, want.wdata);
                commit_count++;
                started = 1'b1;
            end else if (started && !trap_seen) begin
                $display("the commit stream stopped before the trap at time %0t", $time);
                error_count++;
            end
            if (trap.valid && !trap_seen) begin
                trap_seen = 1'b1;
                if (trap.code !== ref_code) mismatch("trap code", trap.code, ref_code);
                if (trap.pc !== ref_trap_pc) mismatch("trap pc", trap.pc, ref_trap_pc);
                if (trap.instr_cnt !== commit_count) begin
                    mismatch("trap instr_cnt", trap.instr_cnt, commit_count);
                end
                if (trap.cycle_cnt !== cycle_count) begin
                    mismatch("trap cycle_cnt", trap.cycle_cnt, cycle_count);
                end
            end
            // rising edges out of reset up to the trap
            if (!trap_seen) begin
                cycle_count++;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_sim_top.sv ====
`default_nettype none

`include "rv64_core_params.svh"

module tb_sim_top;
    timeunit 1ns;
    timeprecision 1ps;

    import rv64_commit_pkg::*;

    localparam int TRAP_TIMEOUT = 2000;
    localparam logic [6:0] OPI = 7'b0010011;

    logic        clock;
    logic        reset;
    logic        imem_load_en;
    logic [7:0]  imem_load_addr;
    logic [31:0] imem_load_data;
    commit_t     commit;
    trap_t       trap;
    int          error_count;
    int          commit_count;
    logic        trap_seen;
    int          tb_errors;
    int          waited;
    logic [31:0] prog [$];

    sim_top i_sim_top (
        .clock          (clock),
        .reset          (reset),
        .imem_load_en   (imem_load_en),
        .imem_load_addr (imem_load_addr),
        .imem_load_data (imem_load_data),
        .commit         (commit),
        .trap           (trap)
    );

    sim_top_checker i_sim_top_checker (
        .clock          (clock),
        .reset          (reset),
        .imem_load_en   (imem_load_en),
        .imem_load_addr (imem_load_addr),
        .imem_load_data (imem_load_data),
        .commit         (commit),
        .trap           (trap),
        .error_count    (error_count),
        .commit_count   (commit_count),
        .trap_seen      (trap_seen)
    );

    bind sim_top sim_top_assertions i_sim_top_assertions (
        .clock  (clock),
        .reset  (reset),
        .commit (commit),
        .trap   (trap)
    );

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    // directed program, operand immediates from $urandom
    task automatic build_program();
        logic [11:0] r1;
        logic [11:0] r2;
        logic [19:0] r3;
        logic [2:0]  br_f3 [6];
        logic [4:0]  lhs [3];
        logic [4:0]  rhs [3];
        br_f3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        lhs   = '{5'd1, 5'd1, 5'd3};
        rhs   = '{5'd1, 5'd3, 5'd1};
        r1 = 12'($urandom);
        r2 = 12'($urandom);
        // negative upper value so signed and unsigned compares differ
        r3 = 20'($urandom) | 20'h80000;
        prog.push_back(i_type(r1, 5'd0, 3'b000, 5'd1, OPI));
        prog.push_back(i_type(r2, 5'd0, 3'b000, 5'd2, OPI));
        prog.push_back({r3, 5'd3, 7'b0110111});
        prog.push_back(r_type(7'h00, 5'd3, 5'd1, 3'b000, 5'd4));
        prog.push_back(r_type(7'h20, 5'd2, 5'd4, 3'b000, 5'd5));
        prog.push_back(r_type(7'h00, 5'd5, 5'd4, 3'b111, 5'd6));
        prog.push_back(r_type(7'h00, 5'd2, 5'd4, 3'b110, 5'd7));
        prog.push_back(r_type(7'h00, 5'd3, 5'd5, 3'b100, 5'd8));
        prog.push_back(r_type(7'h00, 5'd1, 5'd3, 3'b010, 5'd9));
        prog.push_back(r_type(7'h00, 5'd1, 5'd3, 3'b011, 5'd11));
        // shift amounts above 31
        prog.push_back(i_type(12'd40, 5'd4, 3'b001, 5'd12, OPI));
        prog.push_back(i_type(12'd35, 5'd3, 3'b101, 5'd13, OPI));
        prog.push_back(i_type(12'h421, 5'd3, 3'b101, 5'd14, OPI));
        prog.push_back(i_type(12'd45, 5'd0, 3'b000, 5'd15, OPI));
        prog.push_back(r_type(7'h00, 5'd15, 5'd3, 3'b001, 5'd16));
        prog.push_back(r_type(7'h00, 5'd15, 5'd3, 3'b101, 5'd17));
        prog.push_back(r_type(7'h20, 5'd15, 5'd3, 3'b101, 5'd18));
        prog.push_back(i_type(r2, 5'd1, 3'b010, 5'd19, OPI));
        prog.push_back(i_type(r1, 5'd3, 3'b011, 5'd20, OPI));
        prog.push_back(i_type(r2, 5'd4, 3'b100, 5'd21, OPI));
        prog.push_back(i_type(r1, 5'd4, 3'b110, 5'd22, OPI));
        prog.push_back(i_type(r2, 5'd4, 3'b111, 5'd23, OPI));
        // write to x0, then read it back
        prog.push_back(i_type(12'd5, 5'd1, 3'b000, 5'd0, OPI));
        prog.push_back(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd24));
        // sd x4, 16(x0) then ld x25, 16(x0)
        prog.push_back({7'd0, 5'd4, 5'd0, 3'b011, 5'd16, 7'b0100011});
        prog.push_back(i_type(12'd16, 5'd0, 3'b011, 5'd25, 7'b0000011));
        foreach (br_f3[i]) begin
            for (int p = 0; p < 3; p++) begin
                prog.push_back(b_type(13'd8, rhs[p], lhs[p], br_f3[i]));
                prog.push_back(i_type(12'd1, 5'd26, 3'b000, 5'd26, OPI));
            end
        end
        // jal over one word, then jalr with an odd offset past another
        prog.push_back({1'b0, 10'd4, 1'b0, 8'd0, 5'd27, 7'b1101111});
        prog.push_back(i_type(12'd100, 5'd26, 3'b000, 5'd26, OPI));
        prog.push_back(i_type(12'd13, 5'd27, 3'b000, 5'd29, 7'b1100111));
        prog.push_back(i_type(12'd100, 5'd26, 3'b000, 5'd26, OPI));
        prog.push_back(i_type(r1, 5'd0, 3'b000, 5'd10, OPI));
        prog.push_back({25'd0, `TRAP_OPCODE});
        prog.push_back(i_type(12'd7, 5'd0, 3'b000, 5'd26, OPI));
    endtask

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    initial begin
        void'($urandom(32'h3315c2b1));
        reset          = 1'b1;
        imem_load_en   = 1'b0;
        imem_load_addr = '0;
        imem_load_data = '0;
        tb_errors      = 0;
        build_program();
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clock);
            #1;
            imem_load_en   = 1'b1;
            imem_load_addr = i[7:0];
            imem_load_data = prog[i];
        end
        @(posedge clock);
        #1;
        imem_load_en = 1'b0;
        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;
        waited = 0;
        while (!trap.valid && waited < TRAP_TIMEOUT) begin
            @(negedge clock);
            waited++;
        end
        if (!trap.valid) begin
            $display("timeout: no trap after %0d cycles", TRAP_TIMEOUT);
            tb_errors++;
        end
        // give the checker time to see that nothing retires after the trap
        repeat (4) @(negedge clock);
        if (!trap_seen || commit_count == 0) begin
            $display("the checker saw %0d commits and no trap event", commit_count);
            tb_errors++;
        end
        $display("errors: %0d in commit checks, %0d in run control", error_count, tb_errors);
        if (error_count == 0 && tb_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rv64_core.f ====
+incdir+common
common/rv64_decode_pkg.sv
common/rv64_commit_pkg.sv
hdl/inst_fetch.sv
decode/inst_decode.sv
execute/alu_exec.sv
hdl/regfile.sv
hdl/core_mem.sv
hdl/sim_top.sv
verif/sim_top_assertions.sv
verif/sim_top_checker.sv
verif/tb_sim_top.sv

// ==== Bender.yml ====
package:
  name: rv64_core

sources:
  - include_dirs:
      - common
    files:
      - common/rv64_decode_pkg.sv
      - common/rv64_commit_pkg.sv
      - hdl/inst_fetch.sv
      - decode/inst_decode.sv
      - execute/alu_exec.sv
      - hdl/regfile.sv
      - hdl/core_mem.sv
      - hdl/sim_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - verif/sim_top_assertions.sv
      - verif/sim_top_checker.sv
      - verif/tb_sim_top.sv
